// ==== design/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

    // frame geometry
    localparam int FFT_N      = 32;
    localparam int FFT_STAGES = 5;

    // sample widths
    localparam int IN_W      = 12;
    localparam int DATA_W    = 24;
    localparam int FRAC_BITS = 6;
    localparam int OUT_W     = 16;

    // twiddle format, 256 is 1.0
    localparam int TW_W    = 10;
    localparam int TW_FRAC = 8;

    // W_32^j for j = 0..15, real part
    localparam logic signed [TW_W-1:0] TW_RE [FFT_N/2] = '{
        256,
        251,
        237,
        213,
        181,
        142,
        98,
        50,
        0,
        -50,
        -98,
        -142,
        -181,
        -213,
        -237,
        -251
    };

    // imaginary part, negative sine
    localparam logic signed [TW_W-1:0] TW_IM [FFT_N/2] = '{
        0,
        -50,
        -98,
        -142,
        -181,
        -213,
        -237,
        -251,
        -256,
        -251,
        -237,
        -213,
        -181,
        -142,
        -98,
        -50
    };

endpackage

`default_nettype wire

// ==== design/sdf_stage.sv ====
`default_nettype none

module sdf_stage #(
    parameter int STAGE_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_i,
    input  logic signed [fft_pkg::DATA_W-1:0] data_re_i,
    input  logic signed [fft_pkg::DATA_W-1:0] data_im_i,
    output logic                              valid_o,
    output logic signed [fft_pkg::DATA_W-1:0] data_re_o,
    output logic signed [fft_pkg::DATA_W-1:0] data_im_o
);
    import fft_pkg::*;

    localparam int CNT_W    = $clog2(2 * STAGE_DEPTH);
    localparam int TW_STEP  = FFT_N / 2 / STAGE_DEPTH;
    localparam int TW_IDX_W = $clog2(FFT_N / 2);
    localparam int PROD_W   = DATA_W + TW_W + 1;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] pos;
    logic             second_half;
    logic             pos_last;
    logic             adv;
    logic             drain;
    logic             emit;

    logic [TW_IDX_W-1:0]    tw_idx;
    logic signed [TW_W-1:0] tw_re;
    logic signed [TW_W-1:0] tw_im;

    logic signed [DATA_W-1:0] dly_re [STAGE_DEPTH];
    logic signed [DATA_W-1:0] dly_im [STAGE_DEPTH];
    logic signed [DATA_W-1:0] head_re;
    logic signed [DATA_W-1:0] head_im;
    logic signed [DATA_W-1:0] sum_re;
    logic signed [DATA_W-1:0] sum_im;
    logic signed [DATA_W-1:0] dif_re;
    logic signed [DATA_W-1:0] dif_im;
    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;
    logic signed [DATA_W-1:0] push_re;
    logic signed [DATA_W-1:0] push_im;

    // pending drain keeps the stage moving without input
    assign adv         = valid_i | drain;
    assign second_half = cnt[CNT_W-1];
    assign pos         = cnt & CNT_W'(STAGE_DEPTH - 1);
    assign pos_last    = (pos == CNT_W'(STAGE_DEPTH - 1));

    // first half only emits when a stored difference is waiting
    assign emit = adv && (second_half || drain);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            drain <= 1'b0;
        end else if (adv) begin
            // a flush with no input behind it ends back at the first half
            if (pos_last && !valid_i) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // set after the sums, cleared once the differences are out
            if (pos_last) begin
                drain <= second_half;
            end
        end
    end

    // k * 16/D into the shared table
    assign tw_idx = TW_IDX_W'(pos * TW_STEP);
    assign tw_re  = TW_RE[tw_idx];
    assign tw_im  = TW_IM[tw_idx];

    assign head_re = dly_re[STAGE_DEPTH-1];
    assign head_im = dly_im[STAGE_DEPTH-1];

    // butterfly
    assign sum_re = head_re + data_re_i;
    assign sum_im = head_im + data_im_i;
    assign dif_re = head_re - data_re_i;
    assign dif_im = head_im - data_im_i;

    // complex rotation of the difference
    assign prod_re = dif_re * tw_re - dif_im * tw_im;
    assign prod_im = dif_re * tw_im + dif_im * tw_re;

    always_comb begin
        if (second_half) begin
            push_re = DATA_W'(prod_re >>> TW_FRAC);
            push_im = DATA_W'(prod_im >>> TW_FRAC);
        end else if (valid_i) begin
            push_re = data_re_i;
            push_im = data_im_i;
        end else begin
            // flushing
            push_re = '0;
            push_im = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            dly_re[0] <= push_re;
            dly_im[0] <= push_im;
            for (int i = 1; i < STAGE_DEPTH; i++) begin
                dly_re[i] <= dly_re[i-1];
                dly_im[i] <= dly_im[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o   <= 1'b0;
            data_re_o <= '0;
            data_im_o <= '0;
        end else begin
            valid_o <= emit;
            if (emit) begin
                data_re_o <= second_half ? sum_re : head_re;
                data_im_o <= second_half ? sum_im : head_im;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/bit_reverse_buffer.sv ====
`default_nettype none

module bit_reverse_buffer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_i,
    input  logic signed [fft_pkg::DATA_W-1:0] data_re_i,
    input  logic signed [fft_pkg::DATA_W-1:0] data_im_i,
    output logic                              valid_o,
    output logic signed [fft_pkg::DATA_W-1:0] data_re_o,
    output logic signed [fft_pkg::DATA_W-1:0] data_im_o
);
    import fft_pkg::*;

    // two banks, one filling while the other drains
    logic signed [DATA_W-1:0] mem_re [2][FFT_N];
    logic signed [DATA_W-1:0] mem_im [2][FFT_N];

    logic [FFT_STAGES-1:0] wr_cnt;
    logic [FFT_STAGES-1:0] wr_addr;
    logic                  wr_bank;
    logic                  wr_last;

    logic [FFT_STAGES-1:0] rd_cnt;
    logic                  rd_bank;
    logic                  rd_active;

    function automatic logic [FFT_STAGES-1:0] bit_rev(input logic [FFT_STAGES-1:0] a);
        logic [FFT_STAGES-1:0] r;
        for (int i = 0; i < FFT_STAGES; i++) begin
            r[i] = a[FFT_STAGES-1-i];
        end
        return r;
    endfunction

    // pipeline delivers bins in bit-reversed order
    assign wr_addr = bit_rev(wr_cnt);
    assign wr_last = valid_i && (wr_cnt == FFT_STAGES'(FFT_N - 1));

    always_ff @(posedge clk) begin
        if (valid_i) begin
            mem_re[wr_bank][wr_addr] <= data_re_i;
            mem_im[wr_bank][wr_addr] <= data_im_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt  <= '0;
            wr_bank <= 1'b0;
        end else if (valid_i) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_last) begin
                wr_bank <= ~wr_bank;
            end
        end
    end

    // a full bank takes over the read side, even on the last read of the other
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_bank   <= 1'b0;
            rd_cnt    <= '0;
        end else if (wr_last) begin
            rd_active <= 1'b1;
            rd_bank   <= wr_bank;
            rd_cnt    <= '0;
        end else if (rd_active) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == FFT_STAGES'(FFT_N - 1)) begin
                rd_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o   <= 1'b0;
            data_re_o <= '0;
            data_im_o <= '0;
        end else begin
            valid_o <= rd_active;
            if (rd_active) begin
                data_re_o <= mem_re[rd_bank][rd_cnt];
                data_im_o <= mem_im[rd_bank][rd_cnt];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fft32_top.sv ====
`default_nettype none

module fft32_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid_i,
    input  logic signed [fft_pkg::IN_W-1:0]  din_re_i,
    input  logic signed [fft_pkg::IN_W-1:0]  din_im_i,
    output logic                             out_valid_o,
    output logic signed [fft_pkg::OUT_W-1:0] dout_re_o,
    output logic signed [fft_pkg::OUT_W-1:0] dout_im_o
);
    import fft_pkg::*;

    localparam int EXT_W = DATA_W - IN_W - FRAC_BITS;

    logic                     in_vld_q;
    logic signed [DATA_W-1:0] in_re_q;
    logic signed [DATA_W-1:0] in_im_q;

    // index 0 is the scaled input, index s+1 the output of stage s
    logic                     stg_vld [FFT_STAGES+1];
    logic signed [DATA_W-1:0] stg_re  [FFT_STAGES+1];
    logic signed [DATA_W-1:0] stg_im  [FFT_STAGES+1];

    logic                     buf_vld;
    logic signed [DATA_W-1:0] buf_re;
    logic signed [DATA_W-1:0] buf_im;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_vld_q <= 1'b0;
        end else begin
            in_vld_q <= in_valid_i;
        end
    end

    // sign extend, then 6 fraction bits
    always_ff @(posedge clk) begin
        in_re_q <= {{EXT_W{din_re_i[IN_W-1]}}, din_re_i, {FRAC_BITS{1'b0}}};
        in_im_q <= {{EXT_W{din_im_i[IN_W-1]}}, din_im_i, {FRAC_BITS{1'b0}}};
    end

    assign stg_vld[0] = in_vld_q;
    assign stg_re[0]  = in_re_q;
    assign stg_im[0]  = in_im_q;

    // delays 16, 8, 4, 2, 1
    for (genvar s = 0; s < FFT_STAGES; s++) begin : g_stage
        sdf_stage #(
            .STAGE_DEPTH(FFT_N >> (s + 1))
        ) u_stage (
            .clk      (clk),
            .rst_n    (rst_n),
            .valid_i  (stg_vld[s]),
            .data_re_i(stg_re[s]),
            .data_im_i(stg_im[s]),
            .valid_o  (stg_vld[s+1]),
            .data_re_o(stg_re[s+1]),
            .data_im_o(stg_im[s+1])
        );
    end

    bit_reverse_buffer u_reorder (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (stg_vld[FFT_STAGES]),
        .data_re_i(stg_re[FFT_STAGES]),
        .data_im_i(stg_im[FFT_STAGES]),
        .valid_o  (buf_vld),
        .data_re_o(buf_re),
        .data_im_o(buf_im)
    );

    // drop the fraction bits
    assign out_valid_o = buf_vld;
    assign dout_re_o   = OUT_W'(buf_re >>> FRAC_BITS);
    assign dout_im_o   = OUT_W'(buf_im >>> FRAC_BITS);

endmodule

`default_nettype wire

// ==== tests/fft_ref_model.svh ====
`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

// 32-bit LCG with the common multiplier and increment
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// reverse the low nbits of value
function automatic int bit_reversed_index(input int value, input int nbits);
    int r;
    r = 0;
    for (int i = 0; i < nbits; i++) begin
        r = (r << 1) | ((value >> i) & 1);
    end
    return r;
endfunction

// expected output frame of the pipeline for one input frame
function automatic void fft_reference(
    input  logic signed [IN_W-1:0]  in_re  [FFT_N],
    input  logic signed [IN_W-1:0]  in_im  [FFT_N],
    output logic signed [OUT_W-1:0] out_re [FFT_N],
    output logic signed [OUT_W-1:0] out_im [FFT_N]
);
    logic signed [DATA_W-1:0] x_re [FFT_N];
    logic signed [DATA_W-1:0] x_im [FFT_N];
    logic signed [DATA_W-1:0] a_re;
    logic signed [DATA_W-1:0] a_im;
    logic signed [DATA_W-1:0] b_re;
    logic signed [DATA_W-1:0] b_im;
    logic signed [DATA_W-1:0] d_re;
    logic signed [DATA_W-1:0] d_im;
    longint                   p_re;
    longint                   p_im;
    int                       span;
    int                       tw;
    int                       k;

    // sign extend and add the fraction bits
    for (int n = 0; n < FFT_N; n++) begin
        x_re[n] = DATA_W'(longint'(in_re[n]) <<< FRAC_BITS);
        x_im[n] = DATA_W'(longint'(in_im[n]) <<< FRAC_BITS);
    end

    // DIF passes, span 16 down to 1
    for (int s = 0; s < FFT_STAGES; s++) begin
        span = FFT_N >> (s + 1);
        for (int g = 0; g < FFT_N; g += 2 * span) begin
            for (int j = 0; j < span; j++) begin
                a_re = x_re[g+j];
                a_im = x_im[g+j];
                b_re = x_re[g+j+span];
                b_im = x_im[g+j+span];
                d_re = a_re - b_re;
                d_im = a_im - b_im;
                x_re[g+j] = a_re + b_re;
                x_im[g+j] = a_im + b_im;
                // W_32^(j*16/span)
                tw = j * (FFT_N / 2 / span);
                p_re = longint'(d_re) * longint'(TW_RE[tw])
                     - longint'(d_im) * longint'(TW_IM[tw]);
                p_im = longint'(d_re) * longint'(TW_IM[tw])
                     + longint'(d_im) * longint'(TW_RE[tw]);
                x_re[g+j+span] = DATA_W'(p_re >>> TW_FRAC);
                x_im[g+j+span] = DATA_W'(p_im >>> TW_FRAC);
            end
        end
    end

    // in-place DIF leaves bins bit-reversed
    for (int n = 0; n < FFT_N; n++) begin
        k = bit_reversed_index(n, FFT_STAGES);
        out_re[k] = OUT_W'(x_re[n] >>> FRAC_BITS);
        out_im[k] = OUT_W'(x_im[n] >>> FRAC_BITS);
    end
endfunction

`endif

// ==== tests/tb_fft32.sv ====
`default_nettype none

module tb_fft32;
    timeunit 1ns;
    timeprecision 1ps;

    import fft_pkg::*;

    `include "fft_ref_model.svh"

    localparam int NUM_FRAMES = 7;
    localparam int NUM_GAPS   = 4;
    localparam int GAP_CYCLES = 100;
    localparam int IDLE_CHECK = 20;
    localparam int IMPULSE_V  = 300;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * FFT_N + NUM_GAPS * GAP_CYCLES + IDLE_CHECK + 400;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid_i;
    logic signed [IN_W-1:0]  din_re_i;
    logic signed [IN_W-1:0]  din_im_i;
    logic                    out_valid_o;
    logic signed [OUT_W-1:0] dout_re_o;
    logic signed [OUT_W-1:0] dout_im_o;

    logic signed [OUT_W-1:0] exp_re_q [$];
    logic signed [OUT_W-1:0] exp_im_q [$];
    logic signed [IN_W-1:0]  frame_re [FFT_N];
    logic signed [IN_W-1:0]  frame_im [FFT_N];
    logic signed [OUT_W-1:0] ref_re [FFT_N];
    logic signed [OUT_W-1:0] ref_im [FFT_N];
    logic [31:0]             rng_state = 32'd6;
    int                      n_compared = 0;
    int                      valid_run = 0;

    fft32_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .din_re_i   (din_re_i),
        .din_im_i   (din_im_i),
        .out_valid_o(out_valid_o),
        .dout_re_o  (dout_re_o),
        .dout_im_o  (dout_im_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // uniform in -1023..1023
    function automatic logic signed [IN_W-1:0] random_sample();
        int v;
        rng_state = lcg_next(rng_state);
        v = int'(rng_state[30:8] % 2047) - 1023;
        return IN_W'(v);
    endfunction

    function automatic void fill_random_frame();
        for (int n = 0; n < FFT_N; n++) begin
            frame_re[n] = random_sample();
            frame_im[n] = random_sample();
        end
    endfunction

    function automatic void fill_impulse_frame(input int value);
        for (int n = 0; n < FFT_N; n++) begin
            frame_re[n] = (n == 0) ? IN_W'(value) : '0;
            frame_im[n] = '0;
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid_i = 1'b0;
            din_re_i   = '0;
            din_im_i   = '0;
        end
    endtask

    // queue the expected bins, then drive 32 samples without a gap
    task automatic send_frame();
        fft_reference(frame_re, frame_im, ref_re, ref_im);
        for (int n = 0; n < FFT_N; n++) begin
            exp_re_q.push_back(ref_re[n]);
            exp_im_q.push_back(ref_im[n]);
        end
        for (int n = 0; n < FFT_N; n++) begin
            @(negedge clk);
            in_valid_i = 1'b1;
            din_re_i   = frame_re[n];
            din_im_i   = frame_im[n];
        end
    endtask

    task automatic drain_outputs();
        idle_cycles(1);
        while (exp_re_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // valid_run is the length of the current unbroken out_valid_o burst
    always @(posedge clk) begin
        if (rst_n && out_valid_o) begin
            valid_run++;
            if (exp_re_q.size() == 0) begin
                abort_run("out_valid_o went high with no output expected");
            end else begin
                check_value("dout_re_o", dout_re_o, exp_re_q.pop_front());
                check_value("dout_im_o", dout_im_o, exp_im_q.pop_front());
                n_compared++;
            end
        end else begin
            valid_run = 0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, outputs stopped arriving before all frames were checked");
    end

    initial begin
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        din_re_i   = '0;
        din_im_i   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset
        for (int c = 0; c < IDLE_CHECK; c++) begin
            @(negedge clk);
            check_value("out_valid_o", out_valid_o, 32'd0);
            check_value("dout_re_o", dout_re_o, 32'd0);
            check_value("dout_im_o", dout_im_o, 32'd0);
        end

        idle_cycles(GAP_CYCLES);
        fill_impulse_frame(IMPULSE_V);
        send_frame();
        // flat spectrum
        for (int k = 0; k < FFT_N; k++) begin
            check_value("impulse bin re", ref_re[k], IMPULSE_V);
            check_value("impulse bin im", ref_im[k], 32'd0);
        end
        drain_outputs();

        idle_cycles(GAP_CYCLES);
        fill_random_frame();
        send_frame();
        drain_outputs();

        // four frames back to back
        idle_cycles(GAP_CYCLES);
        repeat (4) begin
            fill_random_frame();
            send_frame();
        end
        drain_outputs();
        check_value("out_valid_o run length", valid_run, 4 * FFT_N);

        // recovery after a long idle gap
        idle_cycles(GAP_CYCLES);
        fill_random_frame();
        send_frame();
        drain_outputs();

        if (n_compared != NUM_FRAMES * FFT_N || exp_re_q.size() != 0) begin
            abort_run($sformatf("only %0d of %0d outputs compared, %0d still expected",
                                n_compared, NUM_FRAMES * FFT_N, exp_re_q.size()));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tests
design/fft_pkg.sv
design/sdf_stage.sv
design/bit_reverse_buffer.sv
design/fft32_top.sv
tests/tb_fft32.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FFT testbench, exit status carries the result
cd "$(dirname "$0")" &&
    verilator --binary --timing -Wno-fatal --top-module tb_fft32 \
        -Mdir obj_dir -f tb.f &&
    ./obj_dir/Vtb_fft32 ||
    { echo "FFT testbench run did not pass"; exit 1; }
